/* rtl/extram_pkg.sv */
package extram_pkg;

   localparam int NUM_BANKS      = 4;
   localparam int BANK_BITS      = $clog2(NUM_BANKS);
   localparam int WB_ADDR_WIDTH  = 16;
   localparam int PAGE_SIZE      = 10;                    // Byte address bits inside one bank
   localparam int RAM_ADDR_WIDTH = PAGE_SIZE - 1;         // Word index plus half select
   localparam int WORD_BITS      = PAGE_SIZE - 2;
   localparam int BANK_LSB       = 10;
   localparam int ERR_LSB        = BANK_LSB + BANK_BITS;  // Nonzero bits from here up are unpopulated

   typedef logic [31:0] word_t;
   typedef logic [15:0] half_t;

   typedef enum logic {
      OP_READ,
      OP_WRITE
   } wb_op_e;

   typedef enum logic [3:0] {
      IDLE    = 4'd0,
      READ_1  = 4'd1,
      READ_2  = 4'd2,
      READ_3  = 4'd3,
      READ_4  = 4'd4,
      WRITE_1 = 4'd6,
      WRITE_2 = 4'd7,
      WRITE_3 = 4'd8,
      WRITE_4 = 4'd9
   } ram_state_e;

   typedef struct packed {
      wb_op_e                op;
      logic [WORD_BITS-1:0]  word;
      word_t                 wdata;
   } bank_req_t;

   typedef struct packed {
      logic   ack;
      word_t  rdata;
   } bank_rsp_t;

   typedef struct packed {
      logic [RAM_ADDR_WIDTH-1:0]  addr;   // Bit 0 picks the half
      logic                       ce1n;
      logic                       wen;
      logic                       oen;
   } ram_ctrl_t;

endpackage

/* rtl/extram_bank_decode.sv */
module extram_bank_decode (
   input  logic                                    wb_clk,
   input  logic                                    wb_rst,
   input  logic                                    cyc_i,
   input  logic                                    stb_i,
   input  logic                                    we_i,
   input  logic [extram_pkg::WB_ADDR_WIDTH-1:0]    adr_i,
   input  extram_pkg::word_t                       dat_i,
   input  logic                                    done_i,
   output extram_pkg::bank_req_t                   req_o,
   output logic [extram_pkg::NUM_BANKS-1:0]        bank_stb_o,
   output logic                                    range_err_o
);

   logic                              busy;
   logic                              accept;
   logic                              out_of_range;
   logic [extram_pkg::BANK_BITS-1:0]  bank_sel;

   assign accept       = cyc_i & stb_i & ~busy;   // Master holds stb until ack or err
   assign bank_sel     = adr_i[extram_pkg::BANK_LSB +: extram_pkg::BANK_BITS];
   assign out_of_range = |adr_i[extram_pkg::WB_ADDR_WIDTH-1:extram_pkg::ERR_LSB];

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         busy        <= 1'b0;
         bank_stb_o  <= '0;
         range_err_o <= 1'b0;
      end
      else
      begin
         bank_stb_o  <= '0;   // Single cycle pulses
         range_err_o <= 1'b0;
         if (done_i)
            busy <= 1'b0;
         else if (accept)
            busy <= 1'b1;
         if (accept)
         begin
            if (out_of_range)
               range_err_o <= 1'b1;
            else
               bank_stb_o[bank_sel] <= 1'b1;
         end
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (accept)
      begin
         req_o.op    <= we_i ? extram_pkg::OP_WRITE : extram_pkg::OP_READ;
         req_o.word  <= adr_i[extram_pkg::PAGE_SIZE-1:2];
         req_o.wdata <= dat_i;
      end
   end

endmodule

/* rtl/extram_wb.sv */
module extram_wb (
   input  logic                    wb_clk,
   input  logic                    wb_rst,
   input  logic                    stb_i,
   input  extram_pkg::bank_req_t   req_i,
   output extram_pkg::bank_rsp_t   rsp_o,
   output extram_pkg::ram_ctrl_t   ram_ctrl_o,
   inout  logic [15:0]             ram_d_io
);

   extram_pkg::ram_state_e              state;
   extram_pkg::ram_state_e              state_nxt;
   logic [extram_pkg::WORD_BITS-1:0]    word_q;
   extram_pkg::word_t                   wdata_q;
   extram_pkg::word_t                   rdata_q;
   extram_pkg::half_t                   wr_half;
   logic                                ack_q;
   logic                                drive_en;

   always_comb
   begin
      state_nxt = extram_pkg::IDLE;
      case (state)
         extram_pkg::IDLE:
         begin
            if (stb_i)
            begin
               if (req_i.op == extram_pkg::OP_WRITE)
                  state_nxt = extram_pkg::WRITE_1;
               else
                  state_nxt = extram_pkg::READ_1;
            end
         end
         extram_pkg::READ_1:  state_nxt = extram_pkg::READ_2;
         extram_pkg::READ_2:  state_nxt = extram_pkg::READ_3;
         extram_pkg::READ_3:  state_nxt = extram_pkg::READ_4;
         extram_pkg::WRITE_1: state_nxt = extram_pkg::WRITE_2;
         extram_pkg::WRITE_2: state_nxt = extram_pkg::WRITE_3;
         extram_pkg::WRITE_3: state_nxt = extram_pkg::WRITE_4;
         default:             state_nxt = extram_pkg::IDLE;   // READ_4, WRITE_4
      endcase
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         state <= extram_pkg::IDLE;
         ack_q <= 1'b0;
      end
      else
      begin
         state <= state_nxt;
         ack_q <= (state == extram_pkg::READ_4) || (state == extram_pkg::WRITE_4);
      end
   end

   // Decoder only strobes an idle bank
   always_ff @(posedge wb_clk)
   begin
      if (stb_i)
      begin
         word_q  <= req_i.word;
         wdata_q <= req_i.wdata;
      end
   end

   // Chip returns each half two cycles after its address
   always_ff @(posedge wb_clk)
   begin
      if (state == extram_pkg::READ_3)
         rdata_q[15:0] <= ram_d_io;
      if (state == extram_pkg::READ_4)
         rdata_q[31:16] <= ram_d_io;
   end

   always_comb
   begin
      ram_ctrl_o.addr = {word_q, 1'b0};
      ram_ctrl_o.ce1n = 1'b1;
      ram_ctrl_o.wen  = 1'b1;
      ram_ctrl_o.oen  = 1'b1;
      case (state)
         extram_pkg::READ_1:
            ram_ctrl_o.ce1n = 1'b0;   // Low half address
         extram_pkg::READ_2:
         begin
            ram_ctrl_o.ce1n    = 1'b0;
            ram_ctrl_o.addr[0] = 1'b1;
            ram_ctrl_o.oen     = 1'b0;
         end
         extram_pkg::READ_3:
            ram_ctrl_o.oen = 1'b0;
         extram_pkg::WRITE_1:
         begin
            ram_ctrl_o.ce1n = 1'b0;
            ram_ctrl_o.wen  = 1'b0;
         end
         extram_pkg::WRITE_2:
         begin
            ram_ctrl_o.ce1n    = 1'b0;
            ram_ctrl_o.wen     = 1'b0;
            ram_ctrl_o.addr[0] = 1'b1;
         end
         default:
         begin
         end
      endcase
   end

   assign drive_en = (state == extram_pkg::WRITE_2) || (state == extram_pkg::WRITE_3);
   assign wr_half  = (state == extram_pkg::WRITE_2) ? wdata_q[15:0] : wdata_q[31:16];
   assign ram_d_io = drive_en ? wr_half : 'z;

   assign rsp_o = '{ack: ack_q, rdata: rdata_q};   // Read word valid with the ack

endmodule

/* rtl/extram_resp_merge.sv */
module extram_resp_merge (
   input  logic                    wb_clk,
   input  logic                    wb_rst,
   input  extram_pkg::bank_rsp_t   rsp_i [extram_pkg::NUM_BANKS],
   input  logic                    range_err_i,
   output logic                    ack_o,
   output logic                    err_o,
   output extram_pkg::word_t       dat_o
);

   logic               ack_any;
   extram_pkg::word_t  rdata_sel;

   // Only one bank is ever busy
   always_comb
   begin
      ack_any   = 1'b0;
      rdata_sel = '0;
      for (int i = 0; i < extram_pkg::NUM_BANKS; i++)
      begin
         if (rsp_i[i].ack)
         begin
            ack_any   = 1'b1;
            rdata_sel = rsp_i[i].rdata;
         end
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         ack_o <= 1'b0;
         err_o <= 1'b0;
      end
      else
      begin
         ack_o <= ack_any;
         err_o <= range_err_i;
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (ack_any)
         dat_o <= rdata_sel;   // Held until the next ack
   end

endmodule

/* rtl/extram_top.sv */
module extram_top (
   input  logic                                            wb_clk,
   input  logic                                            wb_rst,
   input  logic                                            cyc_i,
   input  logic                                            stb_i,
   input  logic                                            we_i,
   input  logic [extram_pkg::WB_ADDR_WIDTH-1:0]            adr_i,
   input  extram_pkg::word_t                               dat_i,
   output extram_pkg::word_t                               dat_o,
   output logic                                            ack_o,
   output logic                                            err_o,
   output extram_pkg::ram_ctrl_t                           ram_ctrl_o [extram_pkg::NUM_BANKS],
   inout  logic [extram_pkg::NUM_BANKS-1:0][15:0]          ram_d_io
);

   extram_pkg::bank_req_t               req;
   logic [extram_pkg::NUM_BANKS-1:0]    bank_stb;
   extram_pkg::bank_rsp_t               bank_rsp [extram_pkg::NUM_BANKS];
   logic                                range_err;

   extram_bank_decode u_decode (
      .wb_clk      (wb_clk),
      .wb_rst      (wb_rst),
      .cyc_i       (cyc_i),
      .stb_i       (stb_i),
      .we_i        (we_i),
      .adr_i       (adr_i),
      .dat_i       (dat_i),
      .done_i      (ack_o | err_o),   // Frees the decoder for the next access
      .req_o       (req),
      .bank_stb_o  (bank_stb),
      .range_err_o (range_err)
   );

   for (genvar i = 0; i < extram_pkg::NUM_BANKS; i++)
   begin : g_bank
      extram_wb u_bank (
         .wb_clk     (wb_clk),
         .wb_rst     (wb_rst),
         .stb_i      (bank_stb[i]),
         .req_i      (req),
         .rsp_o      (bank_rsp[i]),
         .ram_ctrl_o (ram_ctrl_o[i]),
         .ram_d_io   (ram_d_io[i])
      );
   end

   extram_resp_merge u_merge (
      .wb_clk      (wb_clk),
      .wb_rst      (wb_rst),
      .rsp_i       (bank_rsp),
      .range_err_i (range_err),
      .ack_o       (ack_o),
      .err_o       (err_o),
      .dat_o       (dat_o)
   );

endmodule

/* testbench/extram_sram_model.sv */
module extram_sram_model (
   input  logic                    wb_clk,
   input  extram_pkg::ram_ctrl_t   ctrl_i,
   inout  logic [15:0]             ram_d_io
);

   extram_pkg::half_t      mem [2**extram_pkg::RAM_ADDR_WIDTH];
   extram_pkg::ram_ctrl_t  stage1;   // Control from the last falling edge
   extram_pkg::ram_ctrl_t  stage2;   // And the one before
   extram_pkg::half_t      dout;
   logic                   dout_en;

   // The write half is on the bus one cycle after its address.
   // Read data leaves the pipeline two cycles after its address.
   always @(negedge wb_clk)
   begin
      stage1 <= ctrl_i;
      stage2 <= stage1;
      if ((stage1.ce1n === 1'b0) && (stage1.wen === 1'b0))
         mem[stage1.addr] <= ram_d_io;
      dout_en <= (stage2.ce1n === 1'b0) && (stage2.wen === 1'b1) && (stage1.oen === 1'b0);
      dout    <= mem[stage2.addr];
   end

   assign ram_d_io = dout_en ? dout : 'z;

endmodule

/* testbench/extram_sva.sv */
module extram_sva (
   input  logic                    wb_clk,
   input  logic                    wb_rst,
   input  logic                    cyc_i,
   input  logic                    stb_i,
   input  logic                    ack_i,
   input  logic                    err_i,
   input  extram_pkg::ram_ctrl_t   ctrl_i [extram_pkg::NUM_BANKS]
);

   logic [extram_pkg::NUM_BANKS-1:0]  ce_n;
   int                                fail_cnt = 0;   // Failed assertions so far

   for (genvar i = 0; i < extram_pkg::NUM_BANKS; i++)
   begin : g_ce
      assign ce_n[i] = ctrl_i[i].ce1n;
   end

   ack_err_excl: assert property (@(posedge wb_clk) disable iff (wb_rst) !(ack_i && err_i))
      else
      begin
         fail_cnt++;
         $error("ack_o and err_o high in the same cycle");
      end

   resp_in_cycle: assert property (@(posedge wb_clk) disable iff (wb_rst)
      (ack_i || err_i) |-> (cyc_i && stb_i))
      else
      begin
         fail_cnt++;
         $error("Response without an active bus cycle");
      end

   one_chip: assert property (@(posedge wb_clk) disable iff (wb_rst) $countones(~ce_n) <= 1)
      else
      begin
         fail_cnt++;
         $error("More than one chip enabled");
      end

   reset_idle: assert property (@(posedge wb_clk) wb_rst |-> (&ce_n))
      else
      begin
         fail_cnt++;
         $error("Chip enabled during reset");
      end

endmodule

bind extram_top extram_sva u_sva (
   .wb_clk (wb_clk),
   .wb_rst (wb_rst),
   .cyc_i  (cyc_i),
   .stb_i  (stb_i),
   .ack_i  (ack_o),
   .err_i  (err_o),
   .ctrl_i (ram_ctrl_o)
);

/* testbench/extram_tb.sv */
module extram_tb;

   localparam int NUM_RANDOM   = 400;
   localparam int NUM_DIRECTED = 11;
   localparam int MAX_CYCLES   = (NUM_RANDOM + NUM_DIRECTED) * 12 + 16 + 100;

   logic                                    wb_clk;
   logic                                    wb_rst;
   logic                                    cyc;
   logic                                    stb;
   logic                                    we;
   logic [extram_pkg::WB_ADDR_WIDTH-1:0]    adr;
   extram_pkg::word_t                       wdata;
   extram_pkg::word_t                       rdata;
   logic                                    ack;
   logic                                    err;
   extram_pkg::ram_ctrl_t                   ram_ctrl [extram_pkg::NUM_BANKS];
   wire  [extram_pkg::NUM_BANKS-1:0][15:0]  ram_d;

   extram_pkg::word_t                       ref_mem [logic [extram_pkg::WB_ADDR_WIDTH-1:0]];
   logic [extram_pkg::WB_ADDR_WIDTH-1:0]    written_q [$];
   integer                                  seed;
   int                                      cycles;

   extram_top uut (
      .wb_clk     (wb_clk),
      .wb_rst     (wb_rst),
      .cyc_i      (cyc),
      .stb_i      (stb),
      .we_i       (we),
      .adr_i      (adr),
      .dat_i      (wdata),
      .dat_o      (rdata),
      .ack_o      (ack),
      .err_o      (err),
      .ram_ctrl_o (ram_ctrl),
      .ram_d_io   (ram_d)
   );

   for (genvar i = 0; i < extram_pkg::NUM_BANKS; i++)
   begin : g_chip
      extram_sram_model u_chip (
         .wb_clk   (wb_clk),
         .ctrl_i   (ram_ctrl[i]),
         .ram_d_io (ram_d[i])
      );
   end

   initial
   begin
      wb_clk = 1'b0;
      forever #2 wb_clk = ~wb_clk;
   end

   initial
   begin
      cycles = 0;
      while (cycles < MAX_CYCLES)
      begin
         @(posedge wb_clk);
         cycles++;
      end
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped");
   end

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_word(input string name, input extram_pkg::word_t exp,
                             input extram_pkg::word_t act);
      if (exp !== act)
         stop_on_error($sformatf("** Error: %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_flag(input string name, input logic [1:0] exp, input logic [1:0] act);
      if (exp !== act)
         stop_on_error($sformatf("** Error: %s ack/err expected %b actual %b", name, exp, act));
   endtask

   task automatic check_latency(input string name, input int exp, input int act);
      if (exp != act)
         stop_on_error($sformatf("** Error: %s latency expected %0d actual %0d", name, exp, act));
   endtask

   task automatic check_pins(input string name, input logic [2:0] exp, input logic [2:0] act);
      if (exp !== act)
         stop_on_error($sformatf("** Error: %s ce1n/wen/oen expected %b actual %b",
                                 name, exp, act));
   endtask

   function automatic logic [31:0] next_random();
      next_random = $random(seed);
   endfunction

   function automatic logic [15:0] make_adr(input logic [3:0] high, input logic [1:0] bank,
                                            input logic [7:0] word);
      make_adr = {high, bank, word, 2'b00};
   endfunction

   task automatic check_idle(input string name);
      check_flag(name, 2'b00, {ack, err});
      for (int i = 0; i < extram_pkg::NUM_BANKS; i++)
         check_pins($sformatf("%s bank %0d", name, i), 3'b111,
                    {ram_ctrl[i].ce1n, ram_ctrl[i].wen, ram_ctrl[i].oen});
   endtask

   // Entered 1 unit after a rising edge, returns 1 unit after the edge that follows the response
   task automatic run_access(input logic op, input logic [15:0] a, input extram_pkg::word_t d,
                             output logic [1:0] resp, output extram_pkg::word_t rd,
                             output int edges);
      edges = 0;
      resp  = 2'b00;
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = op;
      adr   = a;
      wdata = d;
      while (resp == 2'b00)
      begin
         @(posedge wb_clk);
         edges++;   // First edge is the accept edge
         @(negedge wb_clk);
         resp = {ack, err};
         rd   = rdata;
      end
      @(posedge wb_clk);   // stb still held here
      #1;
   endtask

   task automatic checked_access(input string name, input logic op, input logic [15:0] a,
                                 input extram_pkg::word_t d);
      logic [1:0]         resp;
      extram_pkg::word_t  rd;
      int                 edges;
      run_access(op, a, d, resp, rd, edges);
      if (|a[15:12])
      begin
         check_flag(name, 2'b01, resp);
         check_latency(name, 2, edges);
      end
      else
      begin
         check_flag(name, 2'b10, resp);
         check_latency(name, 7, edges);
         if (op)
         begin
            if (!ref_mem.exists(a))
               written_q.push_back(a);
            ref_mem[a] = d;
         end
         else
            check_word(name, ref_mem[a], rd);
      end
   endtask

   task automatic release_bus(input int gap);
      if (gap > 0)
      begin
         cyc = 1'b0;
         stb = 1'b0;
         we  = 1'b0;
      end
      for (int i = 0; i < gap; i++)
      begin
         @(negedge wb_clk);
         check_idle("between accesses");
         @(posedge wb_clk);
         #1;
      end
   endtask

   initial
   begin
      logic [15:0]  a;
      logic [15:0]  alias_adr;
      logic [31:0]  r;
      logic         op;
      seed    = 97340;
      wb_rst  = 1'b1;
      cyc     = 1'b0;
      stb     = 1'b0;
      we      = 1'b0;
      adr     = '0;
      wdata   = '0;
      repeat (16) @(posedge wb_clk);
      #1;
      wb_rst = 1'b0;
      @(negedge wb_clk);
      check_idle("after reset");
      @(posedge wb_clk);
      #1;

      for (int b = 0; b < extram_pkg::NUM_BANKS; b++)
      begin
         r = next_random();
         a = make_adr(4'h0, b[1:0], r[7:0]);
         if (b == 0)
            alias_adr = a;
         checked_access($sformatf("write bank %0d", b), 1'b1, a, next_random());
         release_bus(1);
         checked_access($sformatf("readback bank %0d", b), 1'b0, a, '0);
         release_bus(1);
      end

      // Same low bits as alias_adr, so a stray write would show up there
      a = make_adr(4'h9, alias_adr[11:10], alias_adr[9:2]);
      checked_access("range write", 1'b1, a, ~ref_mem[alias_adr]);
      release_bus(2);
      checked_access("range read", 1'b0, a, '0);
      release_bus(0);
      checked_access("alias readback", 1'b0, alias_adr, '0);
      release_bus(3);

      for (int n = 0; n < NUM_RANDOM; n++)
      begin
         r  = next_random();
         op = r[0] | (written_q.size() == 0);
         if (op)
            a = make_adr(4'h0, r[2:1], r[10:3]);
         else
            a = written_q[r[31:11] % written_q.size()];
         r = next_random();
         if (r[2:0] == 3'd0)   // One access in eight
            a[15:12] = (r[6:3] == 4'h0) ? 4'h1 : r[6:3];
         checked_access($sformatf("random %0d", n), op, a, next_random());
         r = next_random();
         release_bus(r[1:0]);
      end
      release_bus(1);

      if (uut.u_sva.fail_cnt == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

/* list.f */
rtl/extram_pkg.sv
rtl/extram_bank_decode.sv
rtl/extram_wb.sv
rtl/extram_resp_merge.sv
rtl/extram_top.sv
testbench/extram_sram_model.sv
testbench/extram_sva.sv
testbench/extram_tb.sv

/* Bender.yml */
package:
  name: extram

sources:
  # Design
  - rtl/extram_pkg.sv
  - rtl/extram_bank_decode.sv
  - rtl/extram_wb.sv
  - rtl/extram_resp_merge.sv
  - rtl/extram_top.sv

  # Verification
  - target: simulation
    files:
      - testbench/extram_sram_model.sv
      - testbench/extram_sva.sv
      - testbench/extram_tb.sv
